// File: hw/smooth_pkg.sv
`default_nettype none

package smooth_pkg;

  // pixel format
  localparam int PIX_W = 8;

  // frame held in the on-chip store
  localparam int IMG_COLS = 8;
  localparam int IMG_ROWS = 6;

  // row major pixel address that must reach IMG_COLS*IMG_ROWS-1
  localparam int ADDR_W = 6;

  // frame sweep controller
  typedef enum logic [1:0] {
    IDLE,    // waiting for a start strobe
    SWEEP,   // issuing columns band by band
    DRAIN,   // letting the last windows leave the pipeline
    FINISH   // one cycle to raise done
  } sweep_state_t;

endpackage

`default_nettype wire

// File: hw/frame_ram.sv
`default_nettype none

module frame_ram
  import smooth_pkg::*;
(
  input  logic              clk,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [PIX_W-1:0]  wr_data_i,
  input  logic [ADDR_W-1:0] rd_addr_a_i,
  input  logic [ADDR_W-1:0] rd_addr_b_i,
  input  logic [ADDR_W-1:0] rd_addr_c_i,
  output logic [PIX_W-1:0]  rd_data_a_o,
  output logic [PIX_W-1:0]  rd_data_b_o,
  output logic [PIX_W-1:0]  rd_data_c_o
);

  logic [PIX_W-1:0] mem_q [IMG_COLS*IMG_ROWS];  // whole frame, row major

  logic [PIX_W-1:0] rd_a_q;
  logic [PIX_W-1:0] rd_b_q;
  logic [PIX_W-1:0] rd_c_q;

  // host write port
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // three registered read ports, one per row of the band
  // a read that collides with a write sees the old pixel
  always_ff @(posedge clk) begin
    rd_a_q <= mem_q[rd_addr_a_i];  // top row
    rd_b_q <= mem_q[rd_addr_b_i];  // middle row
    rd_c_q <= mem_q[rd_addr_c_i];  // bottom row
  end

  assign rd_data_a_o = rd_a_q;
  assign rd_data_b_o = rd_b_q;
  assign rd_data_c_o = rd_c_q;

endmodule

`default_nettype wire

// File: hw/window_buffer_3x3_datapath.sv
`default_nettype none

module window_buffer_3x3_datapath #(
  parameter int COLS = 5,
  parameter int ROWS = 5
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       count_en,
  input  logic       progress_done,
  input  logic [7:0] S1_i,
  input  logic [7:0] S2_i,
  input  logic [7:0] S3_i,
  output logic [7:0] S1_o,
  output logic [7:0] S2_o,
  output logic [7:0] S3_o,
  output logic [7:0] S4_o,
  output logic [7:0] S5_o,
  output logic [7:0] S6_o,
  output logic [7:0] S7_o,
  output logic [7:0] S8_o,
  output logic [7:0] S9_o,
  output logic       i_col_eq_max,
  output logic       i_col_ge_threshold,
  output logic       i_row_eq_max
);

  localparam int CW = $clog2(COLS);
  localparam int RW = $clog2(ROWS);
  localparam logic [CW-1:0] WIN_LAST = CW'(COLS - 2);   // windows per band
  localparam logic [RW-1:0] BAND_LAST = RW'(ROWS - 3);  // index of the last band

  logic          progress_q;
  logic          progress_fall;
  logic [CW-1:0] win_cnt_q;
  logic [RW-1:0] row_cnt_q;

  logic [7:0] col_a_q;
  logic [7:0] col_b_q;
  logic [7:0] col_c_q;
  logic [7:0] row_a_q [3];  // index 0 holds the newest column
  logic [7:0] row_b_q [3];
  logic [7:0] row_c_q [3];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      progress_q <= 1'b0;
    end else begin
      progress_q <= progress_done;
    end
  end

  assign progress_fall = progress_q && !progress_done;  // end of a frame

  // the window counter wraps one cycle after the band's last window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_cnt_q <= '0;
    end else if (progress_fall || i_col_eq_max) begin
      win_cnt_q <= '0;
    end else if (count_en) begin
      win_cnt_q <= win_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt_q <= '0;
    end else if (progress_fall) begin
      row_cnt_q <= '0;
    end else if (i_col_eq_max) begin
      row_cnt_q <= row_cnt_q + 1'b1;
    end
  end

  assign i_col_eq_max       = (win_cnt_q == WIN_LAST);
  assign i_col_ge_threshold = (win_cnt_q != '0);
  assign i_row_eq_max       = (row_cnt_q == BAND_LAST);

  // an input column register feeds three tap stages per row
  always_ff @(posedge clk) begin
    col_a_q    <= S1_i;
    col_b_q    <= S2_i;
    col_c_q    <= S3_i;
    row_a_q[0] <= col_a_q;
    row_b_q[0] <= col_b_q;
    row_c_q[0] <= col_c_q;
    for (int i = 1; i < 3; i++) begin
      row_a_q[i] <= row_a_q[i-1];
      row_b_q[i] <= row_b_q[i-1];
      row_c_q[i] <= row_c_q[i-1];
    end
  end

  assign S1_o = row_a_q[2];  // oldest column on the left
  assign S2_o = row_a_q[1];
  assign S3_o = row_a_q[0];
  assign S4_o = row_b_q[2];
  assign S5_o = row_b_q[1];
  assign S6_o = row_b_q[0];
  assign S7_o = row_c_q[2];
  assign S8_o = row_c_q[1];
  assign S9_o = row_c_q[0];

  // the controller must never enable a count on a full counter, or a window is lost
  a_win_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count_en |-> (win_cnt_q < WIN_LAST));

endmodule

`default_nettype wire

// File: hw/sweep_ctrl.sv
`default_nettype none

module sweep_ctrl
  import smooth_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic              col_last_i,
  input  logic              band_last_i,
  output logic [ADDR_W-1:0] rd_addr_a_o,
  output logic [ADDR_W-1:0] rd_addr_b_o,
  output logic [ADDR_W-1:0] rd_addr_c_o,
  output logic              count_en_o,
  output logic              progress_o,
  output logic              win_valid_o,
  output logic              busy_o,
  output logic              done_o
);

  sweep_state_t      state_q;
  logic [ADDR_W-1:0] col_q;    // column of the current band
  logic [ADDR_W-1:0] base_q;   // address of the band's top row
  logic [1:0]        drain_q;
  logic [2:0]        vld_q;    // ram read, datapath input, first tap stage
  logic              done_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      col_q   <= '0;
      base_q  <= '0;
      drain_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= SWEEP;
            col_q   <= '0;
            base_q  <= '0;
          end
        end
        SWEEP: begin
          if (col_last_i && band_last_i) begin  // last band has wrapped
            state_q <= DRAIN;
            drain_q <= '0;
          end else if (col_q == ADDR_W'(IMG_COLS - 1)) begin
            col_q <= '0;
            if (!band_last_i) begin  // stay inside the frame on the final band
              base_q <= base_q + ADDR_W'(IMG_COLS);
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        DRAIN: begin
          if (drain_q == 2'd2) begin
            state_q <= FINISH;
          end else begin
            drain_q <= drain_q + 1'b1;
          end
        end
        FINISH: begin
          state_q <= IDLE;
          done_q  <= 1'b1;
        end
      endcase
    end
  end

  // Column 2 onward closes a window. The valid line lines it up with the taps
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[1:0], count_en_o};
    end
  end

  assign rd_addr_a_o = base_q + col_q;
  assign rd_addr_b_o = base_q + col_q + ADDR_W'(IMG_COLS);
  assign rd_addr_c_o = base_q + col_q + ADDR_W'(2 * IMG_COLS);

  assign count_en_o  = (state_q == SWEEP) && (col_q >= ADDR_W'(2));
  assign progress_o  = (state_q == SWEEP) || (state_q == DRAIN);
  assign win_valid_o = vld_q[2];
  assign busy_o      = (state_q != IDLE);
  assign done_o      = done_q;

  // a start while busy must not rewind the sweep to the first band
  a_start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    (start_i && state_q != IDLE) |=> !(state_q == SWEEP && col_q == '0 && base_q == '0));

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |=> !done_o);

endmodule

`default_nettype wire

// File: hw/gauss_kernel_3x3.sv
`default_nettype none

module gauss_kernel_3x3
  import smooth_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  logic [PIX_W-1:0] tap1_i,
  input  logic [PIX_W-1:0] tap2_i,
  input  logic [PIX_W-1:0] tap3_i,
  input  logic [PIX_W-1:0] tap4_i,
  input  logic [PIX_W-1:0] tap5_i,
  input  logic [PIX_W-1:0] tap6_i,
  input  logic [PIX_W-1:0] tap7_i,
  input  logic [PIX_W-1:0] tap8_i,
  input  logic [PIX_W-1:0] tap9_i,
  output logic [PIX_W-1:0] pix_o,
  output logic             valid_o
);

  logic [PIX_W+1:0] top_row;   // 1-2-1 row sum of up to four pixels worth
  logic [PIX_W+1:0] mid_row;
  logic [PIX_W+1:0] bot_row;
  logic [PIX_W+1:0] top_q;
  logic [PIX_W+2:0] mid_q;     // middle row carries the extra weight of two
  logic [PIX_W+1:0] bot_q;
  logic [PIX_W+3:0] total;     // sixteen pixels worth at most
  logic [PIX_W-1:0] pix_q;
  logic             vld1_q;
  logic             vld2_q;

  assign top_row = {2'b00, tap1_i} + {1'b0, tap2_i, 1'b0} + {2'b00, tap3_i};
  assign mid_row = {2'b00, tap4_i} + {1'b0, tap5_i, 1'b0} + {2'b00, tap6_i};
  assign bot_row = {2'b00, tap7_i} + {1'b0, tap8_i, 1'b0} + {2'b00, tap9_i};

  always_ff @(posedge clk) begin
    top_q <= top_row;
    mid_q <= {mid_row, 1'b0};
    bot_q <= bot_row;
  end

  assign total = {2'b00, top_q} + {1'b0, mid_q} + {2'b00, bot_q};

  always_ff @(posedge clk) begin
    pix_q <= total[PIX_W+3:4];  // the weights sum to sixteen so the quotient fits a pixel
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= valid_i;
      vld2_q <= vld1_q;
    end
  end

  assign pix_o   = pix_q;
  assign valid_o = vld2_q;

endmodule

`default_nettype wire

// File: hw/smooth_top.sv
`default_nettype none

module smooth_top
  import smooth_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [PIX_W-1:0]  wr_data_i,
  input  logic              start_i,
  output logic [PIX_W-1:0]  pix_o,
  output logic              pix_valid_o,
  output logic              busy_o,
  output logic              done_o
);

  logic [ADDR_W-1:0] rd_addr_a;
  logic [ADDR_W-1:0] rd_addr_b;
  logic [ADDR_W-1:0] rd_addr_c;
  logic [PIX_W-1:0]  ram_a;
  logic [PIX_W-1:0]  ram_b;
  logic [PIX_W-1:0]  ram_c;
  logic              count_en;
  logic              progress_done;
  logic              win_valid;
  logic              col_last;
  logic              band_last;
  logic [PIX_W-1:0]  tap1;
  logic [PIX_W-1:0]  tap2;
  logic [PIX_W-1:0]  tap3;
  logic [PIX_W-1:0]  tap4;
  logic [PIX_W-1:0]  tap5;
  logic [PIX_W-1:0]  tap6;
  logic [PIX_W-1:0]  tap7;
  logic [PIX_W-1:0]  tap8;
  logic [PIX_W-1:0]  tap9;

  frame_ram u_ram (
    .clk         (clk),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_addr_c_i (rd_addr_c),
    .rd_data_a_o (ram_a),
    .rd_data_b_o (ram_b),
    .rd_data_c_o (ram_c)
  );

  sweep_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .col_last_i  (col_last),
    .band_last_i (band_last),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_addr_c_o (rd_addr_c),
    .count_en_o  (count_en),
    .progress_o  (progress_done),
    .win_valid_o (win_valid),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  window_buffer_3x3_datapath #(
    .COLS (IMG_COLS),
    .ROWS (IMG_ROWS)
  ) u_window (
    .clk                (clk),
    .rst_n              (rst_n),
    .count_en           (count_en),
    .progress_done      (progress_done),
    .S1_i               (ram_a),
    .S2_i               (ram_b),
    .S3_i               (ram_c),
    .S1_o               (tap1),
    .S2_o               (tap2),
    .S3_o               (tap3),
    .S4_o               (tap4),
    .S5_o               (tap5),
    .S6_o               (tap6),
    .S7_o               (tap7),
    .S8_o               (tap8),
    .S9_o               (tap9),
    .i_col_eq_max       (col_last),
    .i_col_ge_threshold (),
    .i_row_eq_max       (band_last)
  );

  gauss_kernel_3x3 u_kernel (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (win_valid),
    .tap1_i  (tap1),
    .tap2_i  (tap2),
    .tap3_i  (tap3),
    .tap4_i  (tap4),
    .tap5_i  (tap5),
    .tap6_i  (tap6),
    .tap7_i  (tap7),
    .tap8_i  (tap8),
    .tap9_i  (tap9),
    .pix_o   (pix_o),
    .valid_o (pix_valid_o)
  );

endmodule

`default_nettype wire

// File: bench/smooth_tb.sv
`default_nettype none

module smooth_tb
  import smooth_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NOUT        = (IMG_ROWS - 2) * (IMG_COLS - 2);
  localparam int LOAD_CYC    = IMG_ROWS * IMG_COLS + 2;
  localparam int SWEEP_CYC   = (IMG_ROWS - 2) * IMG_COLS + 12;  // bands plus pipeline and drain
  localparam int IDLE_CYC    = 10;
  localparam int NUM_FRAMES  = 5;
  localparam int TIMEOUT_CYC = 4 * (IDLE_CYC + NUM_FRAMES * (LOAD_CYC + SWEEP_CYC));

  typedef enum {FILL_RAMP, FILL_RANDOM, FILL_ONES} fill_t;

  logic              clk;
  logic              rst_n;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [PIX_W-1:0]  wr_data;
  logic              start;
  logic [PIX_W-1:0]  pix;
  logic              pix_valid;
  logic              busy;
  logic              done;

  logic [PIX_W-1:0] frame_mem [IMG_ROWS][IMG_COLS];  // copy of what the store holds
  int out_cnt;
  int done_cnt;
  int err_cnt;
  int test_cnt;
  int fail_cnt;
  int cycle_cnt;

  smooth_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .start_i     (start),
    .pix_o       (pix),
    .pix_valid_o (pix_valid),
    .busy_o      (busy),
    .done_o      (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // window with its top left corner at row r, column c
  function automatic logic [PIX_W-1:0] gauss_ref(input int r, input int c);
    int acc;
    int wt [3];
    wt = '{1, 2, 1};
    acc = 0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        acc += wt[i] * wt[j] * int'(frame_mem[r + i][c + j]);
      end
    end
    return PIX_W'(acc / 16);  // truncating divide
  endfunction

  task automatic check_pix(input string name, input int idx, input logic [PIX_W-1:0] exp,
                           input logic [PIX_W-1:0] got);
    if (got !== exp) begin
      $display("ERR %s[%0d]: expected 0x%h, got 0x%h", name, idx, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERR %s: expected 0x%h, got 0x%h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  task automatic load_frame(input fill_t fill);
    logic [PIX_W-1:0] val;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        case (fill)
          FILL_RAMP:   val = PIX_W'(r * 16 + c);
          FILL_RANDOM: val = PIX_W'($urandom());
          default:     val = '1;
        endcase
        frame_mem[r][c] = val;
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= ADDR_W'(r * IMG_COLS + c);
        wr_data <= val;
      end
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic run_frame(input string name, input fill_t fill, input bit restart);
    int errs_before;
    errs_before = err_cnt;
    load_frame(fill);
    out_cnt  = 0;
    done_cnt = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (restart) begin
      repeat (10) @(posedge clk);
      check_flag("busy_o", 1'b1, busy);
      start <= 1'b1;  // lands in the middle of the sweep
      @(posedge clk);
      start <= 1'b0;
    end
    do begin
      @(posedge clk);
    end while (done !== 1'b1);
    repeat (4) @(posedge clk);  // nothing more may arrive after done
    check_flag("busy_o", 1'b0, busy);
    if (out_cnt != NOUT) begin
      report_error($sformatf("frame gave %0d output pixels instead of %0d", out_cnt, NOUT));
    end
    if (done_cnt != 1) begin
      report_error($sformatf("done_o pulsed %0d times instead of once", done_cnt));
    end
    finish_test(name, errs_before);
  endtask

  // outputs arrive in raster order, so the running count is the window index
  always @(posedge clk) begin
    if (rst_n) begin
      if (pix_valid) begin
        if (out_cnt < NOUT) begin
          check_pix("pix_o", out_cnt,
                    gauss_ref(out_cnt / (IMG_COLS - 2), out_cnt % (IMG_COLS - 2)), pix);
        end else begin
          report_error($sformatf("output pixel beyond the %0d windows of the frame", NOUT));
        end
        out_cnt++;
      end
      if (done) begin
        done_cnt++;
        if (out_cnt != NOUT) begin
          report_error($sformatf("done_o came after %0d of %0d pixels", out_cnt, NOUT));
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int errs_before;
    rst_n    = 1'b0;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    start    = 1'b0;
    out_cnt  = 0;
    done_cnt = 0;
    err_cnt  = 0;
    test_cnt = 0;
    fail_cnt = 0;
    void'($urandom(93187));
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    errs_before = err_cnt;
    repeat (IDLE_CYC) begin
      @(posedge clk);
      check_flag("pix_valid_o", 1'b0, pix_valid);
      check_flag("busy_o", 1'b0, busy);
      check_flag("done_o", 1'b0, done);
    end
    finish_test("idle after reset", errs_before);

    run_frame("ramp frame", FILL_RAMP, 1'b0);
    run_frame("random frame", FILL_RANDOM, 1'b0);
    run_frame("all 255 frame", FILL_ONES, 1'b0);
    run_frame("second random frame", FILL_RANDOM, 1'b0);
    run_frame("start while busy", FILL_RANDOM, 1'b1);

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hw/smooth_pkg.sv
hw/frame_ram.sv
hw/window_buffer_3x3_datapath.sv
hw/sweep_ctrl.sv
hw/gauss_kernel_3x3.sv
hw/smooth_top.sv
bench/smooth_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= smooth_tb
SEED      ?= 93187
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= list.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '** FAIL **' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
